//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // ----------------------------------------
    // instruction set
    // ----------------------------------------
    typedef enum logic [2:0] {
        LCD_PRECHARGE = 3'd0,
        LCD_FUNC_SET  = 3'd1,
        LCD_DISP_ON   = 3'd2,
        LCD_CLEAR     = 3'd3,
        LCD_ENTRY     = 3'd4,
        LCD_SET_ADDR  = 3'd5,
        LCD_WRITE     = 3'd6
    } lcd_cmd_e;

    localparam int LCD_CMD_NUM     = 7;
    localparam int LCD_WORD_W      = 10;    // {rs, rw, data}.
    localparam int LCD_ARG_W       = 8;
    localparam int LCD_TIME_W      = 15;
    localparam int LCD_INIT_STEPS  = 5;
    localparam int LCD_EXEC_MAX_US = 15000;

    localparam logic [LCD_WORD_W-1:0] LCD_INSTR [LCD_CMD_NUM] = '{
        10'h030,    // precharge.
        10'h038,    // 8 bit, 2 lines, 5x8 font.
        10'h00C,    // display on, cursor off.
        10'h001,    // clear display.
        10'h006,    // increment, no shift.
        10'h080,    // ddram address in low 7 bits.
        10'h200     // character in low 8 bits.
    };

    localparam logic [LCD_TIME_W-1:0] LCD_EXEC_US [LCD_CMD_NUM] = '{
        15'd15000,
        15'd39,
        15'd39,
        15'd1530,
        15'd39,
        15'd39,
        15'd43
    };

    // ----------------------------------------
    // screen geometry
    // ----------------------------------------
    localparam int LCD_COLS  = 16;
    localparam int LCD_ROWS  = 2;
    localparam int LCD_CHARS = LCD_COLS * LCD_ROWS;
    localparam int LCD_POS_W = 5;

    localparam logic [LCD_ARG_W-1:0] LCD_LINE2_BASE = 8'h40;

    // linear position to ddram address.
    function automatic logic [LCD_ARG_W-1:0] lcd_pos_addr(input logic [LCD_POS_W-1:0] pos);
        if (pos < LCD_POS_W'(LCD_COLS))
            return LCD_ARG_W'(pos);
        else
            return LCD_LINE2_BASE + LCD_ARG_W'(pos - LCD_POS_W'(LCD_COLS));
    endfunction

endpackage

`default_nettype wire

//--- lcd_cmd_if.sv
`timescale 1ns/1ns
`default_nettype none

interface lcd_cmd_if;
    import lcd_pkg::*;

    logic                 start;    // one cycle strobe.
    lcd_cmd_e             cmd;
    logic [LCD_ARG_W-1:0] arg;      // held until finish.
    logic                 finish;   // one cycle pulse.

    modport client (
        output start,
        output cmd,
        output arg,
        input  finish
    );

    modport exec (
        input  start,
        input  cmd,
        input  arg,
        output finish
    );

endinterface

`default_nettype wire

//--- lcd_instr_exec.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_instr_exec #(
    parameter int CLK_PER_US = 50
) (
    input  wire         i_clk,
    input  wire         i_rst_n,
    lcd_cmd_if.exec     cmd_port,
    output logic        o_lcd_en,
    output logic        o_lcd_rs,
    output logic        o_lcd_rw,
    output logic [7:0]  o_lcd_data,
    output logic        o_busy
);
    import lcd_pkg::*;

    localparam int CNT_W = $clog2(LCD_EXEC_MAX_US * CLK_PER_US + 1);

    typedef enum logic {
        S_IDLE,
        S_EXE
    } state_e;

    state_e                state_r;
    logic [LCD_WORD_W-1:0] inst_r;
    logic [CNT_W-1:0]      cnt_r;
    logic [CNT_W-1:0]      last_r;
    logic                  finish_r;

    logic [LCD_WORD_W-1:0] word_w;
    logic [CNT_W-1:0]      cycles_w;

    // ----------------------------------------
    // instruction word and duration
    // ----------------------------------------
    always_comb begin
        word_w = LCD_INSTR[cmd_port.cmd];
        case (cmd_port.cmd)
            LCD_SET_ADDR: word_w[6:0] = cmd_port.arg[6:0];
            LCD_WRITE:    word_w[7:0] = cmd_port.arg;
            default: ;
        endcase
    end

    assign cycles_w = CNT_W'(LCD_EXEC_US[cmd_port.cmd] * CLK_PER_US);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r  <= S_IDLE;
            inst_r   <= '0;
            cnt_r    <= '0;
            last_r   <= '0;
            finish_r <= 1'b0;
        end else begin
            finish_r <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (cmd_port.start) begin
                        state_r <= S_EXE;
                        inst_r  <= word_w;
                        cnt_r   <= '0;
                        last_r  <= cycles_w - 1'b1;   // duration fixed here.
                    end
                end
                S_EXE: begin
                    if (cnt_r == last_r) begin
                        state_r  <= S_IDLE;
                        finish_r <= 1'b1;
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    // enable pulse covers the first microsecond.
    assign o_lcd_en        = (state_r == S_EXE) && (cnt_r < CNT_W'(CLK_PER_US));
    assign o_lcd_rs        = inst_r[9];
    assign o_lcd_rw        = inst_r[8];
    assign o_lcd_data      = inst_r[7:0];
    assign o_busy          = (state_r == S_EXE);
    assign cmd_port.finish = finish_r;

    // the arbiter must hold back every start until the running instruction ends.
    a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (state_r == S_EXE) |-> !cmd_port.start);

    a_en_no_read: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_lcd_en |-> !o_lcd_rw);

endmodule

`default_nettype wire

//--- lcd_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_init_seq (
    input  wire         i_clk,
    input  wire         i_rst_n,
    lcd_cmd_if.client   cmd_port,
    output logic        o_init_done
);
    import lcd_pkg::*;

    localparam int STEP_W = $clog2(LCD_INIT_STEPS + 1);

    logic [STEP_W-1:0] step_r;
    logic              kicked_r;
    logic              start_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            step_r   <= '0;
            kicked_r <= 1'b0;
            start_r  <= 1'b0;
        end else begin
            start_r <= 1'b0;
            if (!kicked_r) begin
                kicked_r <= 1'b1;   // first command right after reset.
                start_r  <= 1'b1;
            end else if (cmd_port.finish && !o_init_done) begin
                step_r  <= step_r + 1'b1;
                start_r <= (step_r != STEP_W'(LCD_INIT_STEPS - 1));
            end
        end
    end

    // ----------------------------------------
    // setup order
    // ----------------------------------------
    always_comb begin
        case (step_r)
            STEP_W'(0): cmd_port.cmd = LCD_PRECHARGE;
            STEP_W'(1): cmd_port.cmd = LCD_FUNC_SET;
            STEP_W'(2): cmd_port.cmd = LCD_DISP_ON;
            STEP_W'(3): cmd_port.cmd = LCD_CLEAR;
            default:    cmd_port.cmd = LCD_ENTRY;
        endcase
    end

    assign cmd_port.start = start_r;
    assign cmd_port.arg   = '0;    // setup words carry no argument.
    assign o_init_done    = (step_r == STEP_W'(LCD_INIT_STEPS));

endmodule

`default_nettype wire

//--- lcd_text_writer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_text_writer (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_init_done,
    input  wire                          i_char_we,
    input  wire [lcd_pkg::LCD_POS_W-1:0] i_char_pos,
    input  wire [7:0]                    i_char,
    lcd_cmd_if.client                    cmd_port
);
    import lcd_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA
    } phase_e;

    logic [7:0]           char_buf [LCD_CHARS];
    logic [LCD_CHARS-1:0] dirty_r;
    phase_e               phase_r;
    logic                 start_r;
    lcd_cmd_e             cmd_r;
    logic [LCD_ARG_W-1:0] arg_r;
    logic [LCD_POS_W-1:0] cur_pos_r;

    logic [LCD_POS_W-1:0] low_pos;
    logic                 found;
    logic                 launch;
    logic                 next_data;
    logic [7:0]           cur_char;

    // lowest dirty position wins.
    always_comb begin
        found   = 1'b0;
        low_pos = '0;
        for (int i = LCD_CHARS - 1; i >= 0; i--) begin
            if (dirty_r[i]) begin
                found   = 1'b1;
                low_pos = LCD_POS_W'(i);
            end
        end
    end

    assign launch    = i_init_done && found &&
                       ((phase_r == W_IDLE) || ((phase_r == W_DATA) && cmd_port.finish));
    assign next_data = (phase_r == W_ADDR) && cmd_port.finish;
    // a host write on the same edge is forwarded.
    assign cur_char  = (i_char_we && (i_char_pos == cur_pos_r)) ? i_char : char_buf[cur_pos_r];

    always_ff @(posedge i_clk) begin
        if (i_char_we)
            char_buf[i_char_pos] <= i_char;
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            dirty_r <= '0;
        end else begin
            if (launch)
                dirty_r[low_pos] <= 1'b0;
            if (i_char_we)
                dirty_r[i_char_pos] <= 1'b1;   // host write wins over the clear.
        end
    end

    // ----------------------------------------
    // refresh engine
    // ----------------------------------------
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase_r <= W_IDLE;
            start_r <= 1'b0;
            cmd_r   <= LCD_SET_ADDR;
        end else begin
            start_r <= 1'b0;
            if (launch) begin
                phase_r <= W_ADDR;
                start_r <= 1'b1;
                cmd_r   <= LCD_SET_ADDR;
            end else if (next_data) begin
                phase_r <= W_DATA;
                start_r <= 1'b1;
                cmd_r   <= LCD_WRITE;
            end else if ((phase_r == W_DATA) && cmd_port.finish) begin
                phase_r <= W_IDLE;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (launch) begin
            cur_pos_r <= low_pos;
            arg_r     <= lcd_pos_addr(low_pos);
        end else if (next_data) begin
            arg_r <= cur_char;
        end
    end

    assign cmd_port.start = start_r;
    assign cmd_port.cmd   = cmd_r;
    assign cmd_port.arg   = arg_r;

    a_data_matches_buf: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (cmd_port.start && (cmd_port.cmd == LCD_WRITE)) |-> (cmd_port.arg == char_buf[cur_pos_r]));

endmodule

`default_nettype wire

//--- lcd_cmd_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_cmd_arbiter (
    input  wire         i_clk,
    input  wire         i_rst_n,
    lcd_cmd_if.exec     init_port,
    lcd_cmd_if.exec     text_port,
    lcd_cmd_if.client   exec_port
);

    logic busy_r;
    logic grant_text_r;
    logic pend_init_r;
    logic pend_text_r;

    logic req_init;
    logic req_text;
    logic fwd;
    logic sel_text;

    assign req_init = init_port.start | pend_init_r;
    assign req_text = text_port.start | pend_text_r;
    assign fwd      = !busy_r && (req_init || req_text);
    // init first when both ask.
    assign sel_text = busy_r ? grant_text_r : !req_init;

    // ----------------------------------------
    // command path
    // ----------------------------------------
    assign exec_port.start = fwd;
    assign exec_port.cmd   = sel_text ? text_port.cmd : init_port.cmd;
    assign exec_port.arg   = sel_text ? text_port.arg : init_port.arg;

    assign init_port.finish = exec_port.finish && !grant_text_r;
    assign text_port.finish = exec_port.finish && grant_text_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            busy_r       <= 1'b0;
            grant_text_r <= 1'b0;
            pend_init_r  <= 1'b0;
            pend_text_r  <= 1'b0;
        end else begin
            if (fwd) begin
                busy_r       <= 1'b1;
                grant_text_r <= sel_text;
            end else if (exec_port.finish) begin
                busy_r <= 1'b0;
            end
            // a start that loses stays pending until the executor frees up.
            pend_init_r <= req_init && !(fwd && !sel_text);
            pend_text_r <= req_text && !(fwd && sel_text);
        end
    end

    a_grant_stable: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (busy_r && !exec_port.finish) |=> ($stable(exec_port.cmd) && $stable(exec_port.arg)));

endmodule

`default_nettype wire

//--- lcd_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_ctrl_top #(
    parameter int CLK_PER_US = 50
) (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_char_we,
    input  wire [lcd_pkg::LCD_POS_W-1:0] i_char_pos,
    input  wire [7:0]                    i_char,
    output wire                          o_lcd_en,
    output wire                          o_lcd_rs,
    output wire                          o_lcd_rw,
    output wire [7:0]                    o_lcd_data,
    output wire                          o_init_done,
    output wire                          o_busy
);

    lcd_cmd_if init_cmd ();
    lcd_cmd_if text_cmd ();
    lcd_cmd_if exec_cmd ();

    // ----------------------------------------
    // clients
    // ----------------------------------------
    lcd_init_seq u_init_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .cmd_port    (init_cmd.client),
        .o_init_done (o_init_done)
    );

    lcd_text_writer u_text_writer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_init_done (o_init_done),
        .i_char_we   (i_char_we),
        .i_char_pos  (i_char_pos),
        .i_char      (i_char),
        .cmd_port    (text_cmd.client)
    );

    lcd_cmd_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .init_port (init_cmd.exec),
        .text_port (text_cmd.exec),
        .exec_port (exec_cmd.client)
    );

    lcd_instr_exec #(
        .CLK_PER_US (CLK_PER_US)
    ) u_instr_exec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .cmd_port   (exec_cmd.exec),
        .o_lcd_en   (o_lcd_en),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_rw   (o_lcd_rw),
        .o_lcd_data (o_lcd_data),
        .o_busy     (o_busy)
    );

endmodule

`default_nettype wire

//--- tb_lcd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lcd_ctrl;

    localparam int CLK_PER_US     = 1;
    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DLY      = 1;
    localparam int MULTI_NUM      = 5;
    localparam int QUIET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 40000;  // init near 16650 plus refreshes, with margin.

    logic       i_clk;
    logic       i_rst_n;
    logic       i_char_we;
    logic [4:0] i_char_pos;
    logic [7:0] i_char;
    wire        o_lcd_en;
    wire        o_lcd_rs;
    wire        o_lcd_rw;
    wire  [7:0] o_lcd_data;
    wire        o_init_done;
    wire        o_busy;

    integer     seed;
    int         cycle_cnt;
    int         err_cnt;
    int         test_cnt;
    int         fail_cnt;
    int         next_word;
    logic       en_d;
    logic       rw_seen;
    logic [8:0] mon_q [$];      // {rs, data}.
    int         mon_cyc [$];
    int         mon_busy [$];   // busy cycles per instruction.

    lcd_ctrl_top #(
        .CLK_PER_US (CLK_PER_US)
    ) UUT (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_char_we   (i_char_we),
        .i_char_pos  (i_char_pos),
        .i_char      (i_char),
        .o_lcd_en    (o_lcd_en),
        .o_lcd_rs    (o_lcd_rs),
        .o_lcd_rw    (o_lcd_rw),
        .o_lcd_data  (o_lcd_data),
        .o_init_done (o_init_done),
        .o_busy      (o_busy)
    );

    initial i_clk = 1'b0;
    always #CLK_HALF i_clk = ~i_clk;

    // ----------------------------------------
    // bus monitor and timeout
    // ----------------------------------------
    always @(posedge i_clk) begin
        if (o_lcd_en && !en_d) begin
            mon_q.push_back({o_lcd_rs, o_lcd_data});
            mon_cyc.push_back(cycle_cnt);
            mon_busy.push_back(0);
        end
        if ((o_busy === 1'b1) && (mon_busy.size() > 0))
            mon_busy[mon_busy.size() - 1] = mon_busy[mon_busy.size() - 1] + 1;
        if (o_lcd_rw)
            rw_seen = 1'b1;
        en_d      = o_lcd_en;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the controller stopped making progress",
                     cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    // set address word for a linear position.
    function automatic logic [7:0] ddram_set_addr(input logic [4:0] pos);
        if (pos < 5'd16)
            return 8'h80 | {3'b000, pos};
        else
            return 8'h80 | (8'h40 + {3'b000, pos} - 8'd16);
    endfunction

    // execution time of a bus word in microseconds.
    function automatic int exec_us_of(input logic [8:0] word);
        if (word[8])
            return 43;
        else if (word[7])
            return 39;
        else if (word[7:0] == 8'h30)
            return 15000;
        else if (word[7:0] == 8'h01)
            return 1530;
        else
            return 39;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s: expected 'h%0h, actual 'h%0h", name, exp, act);
        err_cnt++;
    endtask

    task automatic report_error(input string name, input string what);
        $display("%s: %s", name, what);
        err_cnt++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic write_char(input logic [4:0] pos, input logic [7:0] ch);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_char_we  = 1'b1;
        i_char_pos = pos;
        i_char     = ch;
    endtask

    task automatic end_writes();
        @(posedge i_clk);
        #DRIVE_DLY;
        i_char_we = 1'b0;
    endtask

    task automatic wait_words(input int n);
        while (mon_q.size() < n)
            @(negedge i_clk);
    endtask

    task automatic wait_quiet();
        int idle;
        idle = 0;
        while (idle < QUIET_CYCLES) begin
            @(negedge i_clk);
            if (o_busy)
                idle = 0;
            else
                idle = idle + 1;
        end
    endtask

    task automatic check_pins_zero(input string name);
        if (o_lcd_en !== 1'b0)
            report_mismatch(name, 0, o_lcd_en);
        if (o_lcd_rs !== 1'b0)
            report_mismatch(name, 0, o_lcd_rs);
        if (o_lcd_rw !== 1'b0)
            report_mismatch(name, 0, o_lcd_rw);
        if (o_lcd_data !== 8'h00)
            report_mismatch(name, 0, o_lcd_data);
        if (o_init_done !== 1'b0)
            report_mismatch(name, 0, o_init_done);
    endtask

    task automatic expect_pair(input string name, input logic [4:0] pos, input logic [7:0] ch);
        if (mon_q[next_word] !== {1'b0, ddram_set_addr(pos)})
            report_mismatch(name, {1'b0, ddram_set_addr(pos)}, mon_q[next_word]);
        if (mon_q[next_word + 1] !== {1'b1, ch})
            report_mismatch(name, {1'b1, ch}, mon_q[next_word + 1]);
        next_word = next_word + 2;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_reset_state();
        int errs;
        errs = err_cnt;
        for (int i = 0; i < 8; i++) begin
            @(negedge i_clk);
            check_pins_zero("reset_state");
        end
        @(posedge i_clk);
        #DRIVE_DLY;
        i_rst_n = 1'b0;
        @(posedge i_clk);
        @(negedge i_clk);
        check_pins_zero("reset_state");
        close_test("reset_state", errs);
    endtask

    task automatic test_init_sequence();
        logic [8:0] exp_words [5];
        int         errs;
        errs = err_cnt;
        exp_words = '{9'h030, 9'h038, 9'h00C, 9'h001, 9'h006};
        wait_words(5);
        for (int i = 0; i < 5; i++) begin
            if (mon_q[i] !== exp_words[i])
                report_mismatch("init_sequence", exp_words[i], mon_q[i]);
        end
        while (!o_init_done)
            @(negedge i_clk);
        if (mon_q.size() != 5)
            report_error("init_sequence", "extra instructions appeared before init done");
        if (rw_seen)
            report_error("init_sequence", "RW went high on the bus");
        next_word = 5;
        close_test("init_sequence", errs);
    endtask

    task automatic test_single_char();
        logic [4:0] pos;
        logic [7:0] ch;
        int         errs;
        errs = err_cnt;
        pos  = {1'b1, 4'($random(seed))};   // somewhere on line 2.
        ch   = 8'($random(seed));
        write_char(pos, ch);
        end_writes();
        wait_words(next_word + 2);
        expect_pair("single_char", pos, ch);
        wait_quiet();
        close_test("single_char", errs);
    endtask

    task automatic test_multi_char();
        logic [4:0]  pos [MULTI_NUM];
        logic [7:0]  ch [MULTI_NUM];
        logic [31:0] used;
        logic [4:0]  p;
        int          errs;
        int          j;
        errs = err_cnt;
        used = '0;
        for (int i = 0; i < MULTI_NUM; i++) begin
            p = 5'($random(seed));
            while (used[p])
                p = p + 5'd1;
            used[p] = 1'b1;
        end
        j = 0;
        for (int i = 0; i < 32; i++) begin
            if (used[i]) begin
                pos[j] = 5'(i);
                ch[j]  = 8'($random(seed));
                j      = j + 1;
            end
        end
        // lowest goes first, the rest land while it is being refreshed.
        write_char(pos[0], ch[0]);
        for (int i = MULTI_NUM - 1; i >= 1; i--)
            write_char(pos[i], ch[i]);
        end_writes();
        wait_words(next_word + 2 * MULTI_NUM);
        for (int i = 0; i < MULTI_NUM; i++)
            expect_pair("multi_char", pos[i], ch[i]);
        wait_quiet();
        close_test("multi_char", errs);
    endtask

    task automatic test_rewrite_busy();
        logic [4:0] pos;
        logic [7:0] first_ch;
        logic [7:0] mid_ch;
        logic [7:0] last_ch;
        logic [7:0] seen;
        logic       addr_match;
        logic       hit;
        int         errs;
        errs       = err_cnt;
        pos        = 5'($random(seed));
        first_ch   = 8'($random(seed));
        mid_ch     = 8'($random(seed));
        last_ch    = ~mid_ch;
        addr_match = 1'b0;
        hit        = 1'b0;
        seen       = 8'h00;
        write_char(pos, first_ch);
        end_writes();
        wait_words(next_word + 1);          // set address now in flight.
        write_char(pos, mid_ch);
        write_char(pos, last_ch);
        end_writes();
        wait_quiet();
        for (int i = next_word; i < mon_q.size(); i++) begin
            if (!mon_q[i][8]) begin
                addr_match = (mon_q[i][7:0] == ddram_set_addr(pos));
            end else if (addr_match) begin
                hit  = 1'b1;
                seen = mon_q[i][7:0];
            end
        end
        if (!hit)
            report_error("rewrite_busy", "no data word was written for the position");
        else if (seen !== last_ch)
            report_mismatch("rewrite_busy", last_ch, seen);
        next_word = mon_q.size();
        close_test("rewrite_busy", errs);
    endtask

    task automatic test_exec_timing();
        int errs;
        int gap;
        int min_gap;
        int exp_busy;
        errs = err_cnt;
        for (int i = 0; i + 1 < mon_q.size(); i++) begin
            gap     = mon_cyc[i + 1] - mon_cyc[i];
            min_gap = exec_us_of(mon_q[i]) * CLK_PER_US + 1;
            if (gap < min_gap)
                report_mismatch("exec_timing", min_gap, gap);
            if ((i < 4) && (gap != min_gap + 1))   // init steps run back to back.
                report_mismatch("exec_timing", min_gap + 1, gap);
        end
        // busy spans the execution time of each instruction.
        for (int i = 0; i < mon_busy.size(); i++) begin
            exp_busy = exec_us_of(mon_q[i]) * CLK_PER_US;
            if (mon_busy[i] != exp_busy)
                report_mismatch("exec_timing", exp_busy, mon_busy[i]);
        end
        close_test("exec_timing", errs);
    endtask

    initial begin
        seed       = 32'h7578;
        i_rst_n    = 1'b1;
        i_char_we  = 1'b0;
        i_char_pos = 5'd0;
        i_char     = 8'h00;
        cycle_cnt  = 0;
        err_cnt    = 0;
        test_cnt   = 0;
        fail_cnt   = 0;
        next_word  = 0;
        en_d       = 1'b0;
        rw_seen    = 1'b0;

        test_reset_state();
        test_init_sequence();
        test_single_char();
        test_multi_char();
        test_rewrite_busy();
        test_exec_timing();

        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
lcd_pkg.sv
lcd_cmd_if.sv
lcd_instr_exec.sv
lcd_init_seq.sv
lcd_text_writer.sv
lcd_cmd_arbiter.sv
lcd_ctrl_top.sv
tb_lcd_ctrl.sv

//--- Bender.yml
package:
  name: lcd_ctrl

sources:
  - files:
      - lcd_pkg.sv
      - lcd_cmd_if.sv
      - lcd_instr_exec.sv
      - lcd_init_seq.sv
      - lcd_text_writer.sv
      - lcd_cmd_arbiter.sv
      - lcd_ctrl_top.sv
  - target: test
    files:
      - tb_lcd_ctrl.sv
